//--- src.f
v_mem_axi_pkg.sv
v_mem_xfer_pkg.sv
v_lane_buffer.sv
v_axi_rd_master.sv
v_axi_wr_master.sv
v_mem_subsystem.sv
tb_clk_gen.sv
tb_axi_mem_model.sv
tb_v_mem_subsystem.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_v_mem_subsystem -f src.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_v_mem_subsystem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
   exit 0
fi
exit 1

//--- tb_v_mem_subsystem.sv
`timescale 1ns/1ps

module tb_v_mem_subsystem;
   import v_mem_axi_pkg::*;
   import v_mem_xfer_pkg::*;

   localparam int WORDS = 1024;
   localparam int LIMIT = 4000;

   logic        clk;
   logic        rst_n;
   logic [31:0] baseaddr;
   logic        start;
   xfer_cmd_t   cmd;
   logic        busy, rdone, wdone;
   ar_req_t     ar;
   aw_req_t     aw;
   r_beat_t     r;
   w_beat_t     w;
   logic        arvalid, arready, rvalid, rready, awvalid, awready;
   logic        wvalid, wready, bvalid, bready;
   int          stall_pct;

   int          errors, test_start_errs, pass_cnt, fail_cnt;
   logic [31:0] exp_mem [WORDS];
   logic [3:0]  exp_strb;
   logic [31:0] exp_ar_addr, exp_aw_addr;
   int          ar_left, aw_left, ar_bursts, aw_bursts, valid_seen, w_beat;
   logic [7:0]  aw_len_cur;
   logic        rdone_seen;
   xfer_cmd_t   c;

   tb_clk_gen clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

   tb_axi_mem_model #(.WORDS(WORDS)) mem_inst (
      .clk_i(clk), .rst_n_i(rst_n), .stall_pct_i(stall_pct),
      .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
      .r_o(r), .rvalid_o(rvalid), .rready_i(rready),
      .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
      .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
      .bvalid_o(bvalid), .bready_i(bready)
   );

   v_mem_subsystem v_mem_subsystem_inst (
      .clk(clk), .rst_n_i(rst_n), .ctrl_baseaddr_i(baseaddr),
      .ctrl_start_i(start), .ctrl_cmd_i(cmd), .ctrl_busy_o(busy),
      .ctrl_rdone_o(rdone), .ctrl_wdone_o(wdone),
      .m_axi_ar_o(ar), .m_axi_arvalid_o(arvalid), .m_axi_arready_i(arready),
      .m_axi_r_i(r), .m_axi_rvalid_i(rvalid), .m_axi_rready_o(rready),
      .m_axi_aw_o(aw), .m_axi_awvalid_o(awvalid), .m_axi_awready_i(awready),
      .m_axi_w_o(w), .m_axi_wvalid_o(wvalid), .m_axi_wready_i(wready),
      .m_axi_bvalid_i(bvalid), .m_axi_bready_o(bready)
   );

   // Protocol rules on the master side
   a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      arvalid && !arready |=> arvalid && $stable(ar))
      else begin
         $display("[FAIL] m_axi_ar_o changed before ready, now %h", ar);
         errors++;
      end
   a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      awvalid && !awready |=> awvalid && $stable(aw))
      else begin
         $display("[FAIL] m_axi_aw_o changed before ready, now %h", aw);
         errors++;
      end
   a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
      wvalid && !wready |=> wvalid && $stable(w))
      else begin
         $display("[FAIL] m_axi_w_o changed before ready, now %h", w);
         errors++;
      end
   a_ar_len: assert property (@(posedge clk) disable iff (!rst_n)
      arvalid |-> ar.len < 8'(MAX_BURST))
      else begin
         $display("[FAIL] m_axi_ar_o.len %h", ar.len);
         errors++;
      end
   a_aw_len: assert property (@(posedge clk) disable iff (!rst_n)
      awvalid |-> aw.len < 8'(MAX_BURST))
      else begin
         $display("[FAIL] m_axi_aw_o.len %h", aw.len);
         errors++;
      end
   a_strb: assert property (@(posedge clk) disable iff (!rst_n)
      wvalid |-> w.strb == exp_strb)
      else begin
         $display("[FAIL] m_axi_w_o.strb %h exp %h", w.strb, exp_strb);
         errors++;
      end
   a_rdone_pulse: assert property (@(posedge clk) disable iff (!rst_n) rdone |=> !rdone)
      else begin
         $display("ctrl_rdone_o stayed high for two cycles");
         errors++;
      end
   a_wdone_pulse: assert property (@(posedge clk) disable iff (!rst_n) wdone |=> !wdone)
      else begin
         $display("ctrl_wdone_o stayed high for two cycles");
         errors++;
      end
   a_busy_done: assert property (@(posedge clk) disable iff (!rst_n) wdone |-> busy)
      else begin
         $display("ctrl_busy_o low while ctrl_wdone_o pulsed");
         errors++;
      end
   a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(busy) |-> $past(wdone))
      else begin
         $display("ctrl_busy_o fell without ctrl_wdone_o");
         errors++;
      end

   // Burst sequence and wlast placement
   always @(posedge clk) begin
      if (rst_n) begin
         if (arvalid || awvalid || wvalid) valid_seen++;
         if (rdone) rdone_seen = 1'b1;
         if (arvalid && arready) begin
            a_ar_seq: assert (ar.addr == exp_ar_addr &&
                              int'(ar.len) + 1 == beats_in_next_burst(ar_left))
               else begin
                  $display("[FAIL] m_axi_ar_o addr %h len %h exp %h %h", ar.addr, ar.len,
                           exp_ar_addr, 8'(beats_in_next_burst(ar_left) - 1));
                  errors++;
               end
            exp_ar_addr += 32'(beats_in_next_burst(ar_left)) * 4;
            ar_left -= beats_in_next_burst(ar_left);
            ar_bursts++;
         end
         if (awvalid && awready) begin
            a_aw_seq: assert (aw.addr == exp_aw_addr &&
                              int'(aw.len) + 1 == beats_in_next_burst(aw_left))
               else begin
                  $display("[FAIL] m_axi_aw_o addr %h len %h exp %h %h", aw.addr, aw.len,
                           exp_aw_addr, 8'(beats_in_next_burst(aw_left) - 1));
                  errors++;
               end
            exp_aw_addr += 32'(beats_in_next_burst(aw_left)) * 4;
            aw_len_cur = 8'(beats_in_next_burst(aw_left) - 1);
            aw_left -= beats_in_next_burst(aw_left);
            aw_bursts++;
            w_beat = 0;
         end
         if (wvalid && wready) begin
            a_wlast: assert (w.last == (w_beat == int'(aw_len_cur)))
               else begin
                  $display("[FAIL] m_axi_w_o.last %h at beat %h exp %h", w.last, w_beat,
                           w_beat == int'(aw_len_cur));
                  errors++;
               end
            w_beat++;
         end
         if (wdone) begin
            a_rd_first: assert (rdone_seen)
               else begin
                  $display("write done came before read done");
                  errors++;
               end
         end
      end
   end

   // Beats of the next burst for the words still to move
   function automatic int beats_in_next_burst(int left);
      return (left > MAX_BURST) ? MAX_BURST : left;
   endfunction

   // Each word's pattern depends on its full index
   function automatic logic [31:0] fill(int k);
      return (32'(k) * 32'h9E3779B1) ^ 32'h0F1E2D3C;
   endfunction

   task automatic init_mem();
      for (int k = 0; k < WORDS; k++) begin
         mem_inst.mem[k] = fill(k);
         exp_mem[k] = fill(k);
      end
   endtask

   task automatic apply_ref(xfer_cmd_t x);
      int         src;
      int         dst;
      logic [3:0] s;
      src = int'((baseaddr + x.raddr_offset) >> 2);
      dst = int'((baseaddr + x.waddr_offset) >> 2);
      s = x.wstrb_msk_en ? x.wstrb_msk : 4'hf;
      for (int i = 0; i < int'(x.xfer_size); i++) begin
         for (int b = 0; b < 4; b++) begin
            if (s[b]) exp_mem[dst+i][8*b +: 8] = exp_mem[src+i][8*b +: 8];
         end
      end
   endtask

   task automatic launch(xfer_cmd_t x);
      @(posedge clk);
      #1;
      exp_ar_addr = baseaddr + x.raddr_offset;
      exp_aw_addr = baseaddr + x.waddr_offset;
      ar_left = int'(x.xfer_size);
      aw_left = int'(x.xfer_size);
      ar_bursts = 0;
      aw_bursts = 0;
      valid_seen = 0;
      rdone_seen = 1'b0;
      exp_strb = x.wstrb_msk_en ? x.wstrb_msk : 4'hf;
      cmd = x;
      start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
   endtask

   task automatic wait_wdone();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!wdone && n < LIMIT);
      if (!wdone) begin
         $display("timeout: no write done after %0d cycles", LIMIT);
         errors++;
      end
      repeat (2) @(posedge clk);
      #1;
   endtask

   task automatic check_mem();
      for (int k = 0; k < WORDS; k++) begin
         a_mem: assert (mem_inst.mem[k] === exp_mem[k])
            else begin
               $display("[FAIL] mem[%h] got %h exp %h", k, mem_inst.mem[k], exp_mem[k]);
               errors++;
            end
      end
   endtask

   task automatic end_test(string name);
      if (errors == test_start_errs) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: failed", name);
      end
      test_start_errs = errors;
   endtask

   // One copy from source to destination with the given stall rate
   task automatic copy_test(int size, logic en, logic [3:0] m, int pct);
      xfer_cmd_t x;
      x = '{32'h000, 32'h400, 16'(size), en, m};
      stall_pct = pct;
      init_mem();
      apply_ref(x);
      launch(x);
      wait_wdone();
      check_mem();
   endtask

   initial begin
      int n;
      void'($urandom(45));
      baseaddr = 32'h100;
      start = 1'b0;
      cmd = '0;
      stall_pct = 20;
      errors = 0;
      test_start_errs = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      exp_strb = 4'hf;
      n = 0;
      while (!rst_n && n < 10) begin
         @(posedge clk);
         n++;
      end
      if (!rst_n) begin
         $display("reset was never released");
         errors++;
      end
      @(negedge clk);
      a_reset: assert (!arvalid && !awvalid && !wvalid && !rready && !bready &&
                       !busy && !rdone && !wdone)
         else begin
            $display("[FAIL] outputs after reset %h", {arvalid, awvalid, wvalid, rready,
                     bready, busy, rdone, wdone});
            errors++;
         end
      init_mem();
      launch(xfer_cmd_t'{32'h0, 32'h400, 16'd0, 1'b0, 4'h0});
      wait_wdone();
      a_zero: assert (rdone_seen && valid_seen == 0)
         else begin
            $display("zero-length command raised a valid or missed read done");
            errors++;
         end
      end_test("reset_and_zero_length");

      copy_test(16, 1'b0, 4'h0, 20);
      a_one_burst: assert (ar_bursts == 1 && aw_bursts == 1)
         else begin
            $display("[FAIL] ar_bursts %h aw_bursts %h exp 1", ar_bursts, aw_bursts);
            errors++;
         end
      end_test("copy_16");

      copy_test(12, 1'b1, 4'h5, 20);
      end_test("mask_5");

      copy_test(37, 1'b0, 4'h0, 20);
      a_three: assert (ar_bursts == 3 && aw_bursts == 3)
         else begin
            $display("[FAIL] ar_bursts %h aw_bursts %h exp 3", ar_bursts, aw_bursts);
            errors++;
         end
      end_test("copy_37");

      copy_test(40, 1'b0, 4'h0, 80);
      end_test("heavy_stall");

      stall_pct = 30;
      init_mem();
      c = '{32'h000, 32'h400, 16'd20, 1'b0, 4'h0};
      apply_ref(c);
      launch(c);
      repeat (5) @(posedge clk);
      #1;
      a_busy_mid: assert (busy)
         else begin
            $display("second start was not applied during a busy transfer");
            errors++;
         end
      cmd = '{32'h040, 32'h800, 16'd8, 1'b0, 4'h0};
      start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
      wait_wdone();
      check_mem();
      end_test("start_while_busy");

      $display("tests passed %0d failed %0d errors %0d", pass_cnt, fail_cnt, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- tb_axi_mem_model.sv
`timescale 1ns/1ps

module tb_axi_mem_model #(
   parameter int WORDS = 1024
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  int                     stall_pct_i,
   input  v_mem_axi_pkg::ar_req_t ar_i,
   input  logic                   arvalid_i,
   output logic                   arready_o,
   output v_mem_axi_pkg::r_beat_t r_o,
   output logic                   rvalid_o,
   input  logic                   rready_i,
   input  v_mem_axi_pkg::aw_req_t aw_i,
   input  logic                   awvalid_i,
   output logic                   awready_o,
   input  v_mem_axi_pkg::w_beat_t w_i,
   input  logic                   wvalid_i,
   output logic                   wready_o,
   output logic                   bvalid_o,
   input  logic                   bready_i
);
   import v_mem_axi_pkg::*;

   logic [31:0]              mem [WORDS];
   logic [$clog2(WORDS)-1:0] r_idx;
   logic [$clog2(WORDS)-1:0] w_idx;
   logic [7:0]               r_left;
   logic                     r_act;
   logic                     w_act;
   logic                     ar_f;
   logic                     r_f;
   logic                     aw_f;
   logic                     w_f;
   logic                     b_f;
   ar_req_t                  ar_s;
   aw_req_t                  aw_s;
   w_beat_t                  w_s;

   // True when this cycle is not stalled
   function automatic logic go();
      return ($urandom % 100) >= stall_pct_i;
   endfunction

   always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         arready_o = 1'b0;
         rvalid_o  = 1'b0;
         r_o       = '0;
         awready_o = 1'b0;
         wready_o  = 1'b0;
         bvalid_o  = 1'b0;
         r_act     = 1'b0;
         w_act     = 1'b0;
         r_idx     = '0;
         w_idx     = '0;
         r_left    = '0;
      end else begin
         // Handshakes seen at the edge, outputs change just after it
         ar_f = arvalid_i & arready_o;
         r_f  = rvalid_o & rready_i;
         aw_f = awvalid_i & awready_o;
         w_f  = wvalid_i & wready_o;
         b_f  = bvalid_o & bready_i;
         ar_s = ar_i;
         aw_s = aw_i;
         w_s  = w_i;
         #1;
         if (ar_f) begin
            r_act  = 1'b1;
            r_idx  = ar_s.addr[$clog2(WORDS)+1:2];
            r_left = ar_s.len;
         end
         if (r_f) begin
            if (r_left == 8'd0) begin
               r_act = 1'b0;
            end else begin
               r_idx  = r_idx + 1'b1;
               r_left = r_left - 1'b1;
            end
         end
         if (!(rvalid_o && !r_f)) begin
            rvalid_o = r_act & go();
         end
         r_o.data  = mem[r_idx];
         r_o.last  = (r_left == 8'd0);
         arready_o = ~r_act & go();
         if (b_f) begin
            bvalid_o = 1'b0;
         end
         if (aw_f) begin
            w_act = 1'b1;
            w_idx = aw_s.addr[$clog2(WORDS)+1:2];
         end
         if (w_f) begin
            for (int b = 0; b < 4; b++) begin
               if (w_s.strb[b]) begin
                  mem[w_idx][8*b +: 8] = w_s.data[8*b +: 8];
               end
            end
            w_idx = w_idx + 1'b1;
            if (w_s.last) begin
               w_act    = 1'b0;
               bvalid_o = 1'b1;
            end
         end
         awready_o = ~w_act & ~bvalid_o & go();
         wready_o  = w_act & go();
      end
   end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

   // Reset spans the first two rising edges
   initial begin
      rst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      #1 rst_n_o = 1'b1;
   end

endmodule

//--- v_mem_subsystem.sv
`timescale 1ns/1ps

module v_mem_subsystem (
   input  logic                                 clk,
   input  logic                                 rst_n_i,
   input  logic [v_mem_axi_pkg::AXI_ADDR_W-1:0] ctrl_baseaddr_i,
   input  logic                                 ctrl_start_i,
   input  v_mem_xfer_pkg::xfer_cmd_t            ctrl_cmd_i,
   output logic                                 ctrl_busy_o,
   output logic                                 ctrl_rdone_o,
   output logic                                 ctrl_wdone_o,
   output v_mem_axi_pkg::ar_req_t               m_axi_ar_o,
   output logic                                 m_axi_arvalid_o,
   input  logic                                 m_axi_arready_i,
   input  v_mem_axi_pkg::r_beat_t               m_axi_r_i,
   input  logic                                 m_axi_rvalid_i,
   output logic                                 m_axi_rready_o,
   output v_mem_axi_pkg::aw_req_t               m_axi_aw_o,
   output logic                                 m_axi_awvalid_o,
   input  logic                                 m_axi_awready_i,
   output v_mem_axi_pkg::w_beat_t               m_axi_w_o,
   output logic                                 m_axi_wvalid_o,
   input  logic                                 m_axi_wready_i,
   input  logic                                 m_axi_bvalid_i,
   output logic                                 m_axi_bready_o
);
   import v_mem_axi_pkg::*;
   import v_mem_xfer_pkg::*;

   logic                                xfer_start;
   logic [V_LANES-1:0]                  lane_push;
   logic [AXI_DATA_W-1:0]               lane_push_data;
   logic [V_LANES-1:0]                  lane_full;
   logic [V_LANES-1:0]                  lane_pop;
   logic [V_LANES-1:0]                  lane_empty;
   logic [V_LANES-1:0][AXI_DATA_W-1:0]  lane_head;

   // A start during a transfer reaches neither master
   assign xfer_start = ctrl_start_i & ~ctrl_busy_o;

   v_axi_rd_master rd_master_inst (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .start_i          (xfer_start),
      .cmd_i            (ctrl_cmd_i),
      .baseaddr_i       (ctrl_baseaddr_i),
      .ar_o             (m_axi_ar_o),
      .arvalid_o        (m_axi_arvalid_o),
      .arready_i        (m_axi_arready_i),
      .rvalid_i         (m_axi_rvalid_i),
      .rready_o         (m_axi_rready_o),
      .r_i              (m_axi_r_i),
      .lane_full_i      (lane_full),
      .lane_push_o      (lane_push),
      .lane_push_data_o (lane_push_data),
      .rdone_o          (ctrl_rdone_o)
   );

   // One FIFO per vector lane slice
   for (genvar g = 0; g < V_LANES; g++) begin : gen_lane
      v_lane_buffer lane_inst (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .push_i      (lane_push[g]),
         .push_data_i (lane_push_data),
         .pop_i       (lane_pop[g]),
         .head_o      (lane_head[g]),
         .empty_o     (lane_empty[g]),
         .full_o      (lane_full[g])
      );
   end

   v_axi_wr_master wr_master_inst (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .start_i      (xfer_start),
      .cmd_i        (ctrl_cmd_i),
      .baseaddr_i   (ctrl_baseaddr_i),
      .aw_o         (m_axi_aw_o),
      .awvalid_o    (m_axi_awvalid_o),
      .awready_i    (m_axi_awready_i),
      .w_o          (m_axi_w_o),
      .wvalid_o     (m_axi_wvalid_o),
      .wready_i     (m_axi_wready_i),
      .bvalid_i     (m_axi_bvalid_i),
      .bready_o     (m_axi_bready_o),
      .lane_head_i  (lane_head),
      .lane_empty_i (lane_empty),
      .lane_pop_o   (lane_pop),
      .wdone_o      (ctrl_wdone_o),
      .busy_o       (ctrl_busy_o)
   );

endmodule

//--- v_axi_wr_master.sv
`timescale 1ns/1ps

module v_axi_wr_master (
   input  logic                                 clk,
   input  logic                                 rst_n_i,
   input  logic                                 start_i,
   input  v_mem_xfer_pkg::xfer_cmd_t            cmd_i,
   input  logic [v_mem_axi_pkg::AXI_ADDR_W-1:0] baseaddr_i,
   output v_mem_axi_pkg::aw_req_t               aw_o,
   output logic                                 awvalid_o,
   input  logic                                 awready_i,
   output v_mem_axi_pkg::w_beat_t               w_o,
   output logic                                 wvalid_o,
   input  logic                                 wready_i,
   input  logic                                 bvalid_i,
   output logic                                 bready_o,
   input  logic [v_mem_xfer_pkg::V_LANES-1:0][v_mem_axi_pkg::AXI_DATA_W-1:0] lane_head_i,
   input  logic [v_mem_xfer_pkg::V_LANES-1:0]   lane_empty_i,
   output logic [v_mem_xfer_pkg::V_LANES-1:0]   lane_pop_o,
   output logic                                 wdone_o,
   output logic                                 busy_o
);
   import v_mem_axi_pkg::*;
   import v_mem_xfer_pkg::*;

   logic                   busy_r;
   logic [XFER_SIZE_W-1:0] remain;
   logic [AXI_ADDR_W-1:0]  next_addr;
   logic [AXI_STRB_W-1:0]  strb_r;
   logic [LANE_IDX_W-1:0]  lane_idx;
   logic [7:0]             beat_left;
   logic                   w_active;
   logic                   start_ok;
   logic                   w_fire;
   logic                   b_fire;
   logic [XFER_SIZE_W-1:0] burst_cnt;
   logic [XFER_SIZE_W-1:0] burst_beats;
   logic [AXI_ADDR_W-1:0]  burst_addr;
   logic                   issue;
   logic                   finish;

   assign start_ok = start_i & ~busy_r;
   assign b_fire   = bvalid_i & bready_o;

   assign burst_cnt   = start_ok ? cmd_i.xfer_size : remain;
   assign burst_addr  = start_ok ? baseaddr_i + cmd_i.waddr_offset : next_addr;
   assign burst_beats = (burst_cnt > XFER_SIZE_W'(MAX_BURST)) ? XFER_SIZE_W'(MAX_BURST)
                                                             : burst_cnt;

   // Next AW waits for the previous burst's B
   assign issue  = (start_ok && cmd_i.xfer_size != '0) || (b_fire && remain != '0);
   assign finish = (start_ok && cmd_i.xfer_size == '0) || (b_fire && remain == '0);

   // W is offered as soon as the lane in turn holds its element
   assign wvalid_o = w_active & ~lane_empty_i[lane_idx];
   assign w_fire   = wvalid_o & wready_i;

   always_comb begin
      w_o.data = lane_head_i[lane_idx];
      w_o.strb = strb_r;
      w_o.last = (beat_left == 8'd0);
   end

   always_comb begin
      lane_pop_o           = '0;
      lane_pop_o[lane_idx] = w_fire;
   end

   // Busy covers the done cycle and drops right after it
   assign busy_o = busy_r;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_r    <= 1'b0;
         awvalid_o <= 1'b0;
         w_active  <= 1'b0;
         bready_o  <= 1'b0;
         beat_left <= '0;
         remain    <= '0;
         lane_idx  <= '0;
         wdone_o   <= 1'b0;
      end else begin
         wdone_o <= finish;
         if (start_ok) begin
            busy_r <= 1'b1;
         end else if (wdone_o) begin
            busy_r <= 1'b0;
         end
         if (issue) begin
            awvalid_o <= 1'b1;
            remain    <= burst_cnt - burst_beats;
         end else if (awvalid_o && awready_i) begin
            awvalid_o <= 1'b0;
            w_active  <= 1'b1;
            beat_left <= aw_o.len;
         end
         if (w_fire) begin
            if (beat_left == 8'd0) begin
               w_active <= 1'b0;
               bready_o <= 1'b1;
            end else begin
               beat_left <= beat_left - 1'b1;
            end
         end
         if (b_fire) begin
            bready_o <= 1'b0;
         end
         // Gather order matches the scatter order of the read side
         if (start_ok) begin
            lane_idx <= '0;
         end else if (w_fire) begin
            lane_idx <= (lane_idx == LANE_IDX_W'(V_LANES-1)) ? '0 : lane_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start_ok) begin
         strb_r <= cmd_i.wstrb_msk_en ? cmd_i.wstrb_msk : '1;
      end
      if (issue) begin
         aw_o.addr <= burst_addr;
         aw_o.len  <= 8'(burst_beats - 1'b1);
         next_addr <= burst_addr + (AXI_ADDR_W'(burst_beats) << 2);
      end
   end

endmodule

//--- v_axi_rd_master.sv
`timescale 1ns/1ps

module v_axi_rd_master (
   input  logic                                 clk,
   input  logic                                 rst_n_i,
   input  logic                                 start_i,
   input  v_mem_xfer_pkg::xfer_cmd_t            cmd_i,
   input  logic [v_mem_axi_pkg::AXI_ADDR_W-1:0] baseaddr_i,
   output v_mem_axi_pkg::ar_req_t               ar_o,
   output logic                                 arvalid_o,
   input  logic                                 arready_i,
   input  logic                                 rvalid_i,
   output logic                                 rready_o,
   input  v_mem_axi_pkg::r_beat_t               r_i,
   input  logic [v_mem_xfer_pkg::V_LANES-1:0]   lane_full_i,
   output logic [v_mem_xfer_pkg::V_LANES-1:0]   lane_push_o,
   output logic [v_mem_axi_pkg::AXI_DATA_W-1:0] lane_push_data_o,
   output logic                                 rdone_o
);
   import v_mem_axi_pkg::*;
   import v_mem_xfer_pkg::*;

   logic [XFER_SIZE_W-1:0] remain;
   logic [AXI_ADDR_W-1:0]  next_addr;
   logic [LANE_IDX_W-1:0]  lane_idx;
   logic                   burst_open;
   logic                   r_fire;
   logic                   burst_end;
   logic [XFER_SIZE_W-1:0] burst_cnt;
   logic [XFER_SIZE_W-1:0] burst_beats;
   logic [AXI_ADDR_W-1:0]  burst_addr;
   logic                   issue;
   logic                   finish;

   // Stall R while the lane owning the next element has no room
   assign rready_o  = burst_open & ~lane_full_i[lane_idx];
   assign r_fire    = rvalid_i & rready_o;
   assign burst_end = r_fire & r_i.last;

   // A start seeds the first burst straight from the command
   assign burst_cnt   = start_i ? cmd_i.xfer_size : remain;
   assign burst_addr  = start_i ? baseaddr_i + cmd_i.raddr_offset : next_addr;
   assign burst_beats = (burst_cnt > XFER_SIZE_W'(MAX_BURST)) ? XFER_SIZE_W'(MAX_BURST)
                                                             : burst_cnt;

   assign issue  = (start_i && cmd_i.xfer_size != '0) || (burst_end && remain != '0);
   assign finish = (start_i && cmd_i.xfer_size == '0) || (burst_end && remain == '0);

   always_comb begin
      lane_push_o           = '0;
      lane_push_o[lane_idx] = r_fire;
   end

   assign lane_push_data_o = r_i.data;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         arvalid_o  <= 1'b0;
         burst_open <= 1'b0;
         remain     <= '0;
         lane_idx   <= '0;
         rdone_o    <= 1'b0;
      end else begin
         rdone_o <= finish;
         if (issue) begin
            arvalid_o <= 1'b1;
            remain    <= burst_cnt - burst_beats;
         end else if (arvalid_o && arready_i) begin
            arvalid_o  <= 1'b0;
            burst_open <= 1'b1;
         end
         if (burst_end) begin
            burst_open <= 1'b0;
         end
         // Element i goes to lane i modulo V_LANES
         if (start_i) begin
            lane_idx <= '0;
         end else if (r_fire) begin
            lane_idx <= (lane_idx == LANE_IDX_W'(V_LANES-1)) ? '0 : lane_idx + 1'b1;
         end
      end
   end

   // Next burst starts right after the bytes of this one
   always_ff @(posedge clk) begin
      if (issue) begin
         ar_o.addr <= burst_addr;
         ar_o.len  <= 8'(burst_beats - 1'b1);
         next_addr <= burst_addr + (AXI_ADDR_W'(burst_beats) << 2);
      end
   end

endmodule

//--- v_lane_buffer.sv
`timescale 1ns/1ps

module v_lane_buffer (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  logic                                push_i,
   input  logic [v_mem_axi_pkg::AXI_DATA_W-1:0] push_data_i,
   input  logic                                pop_i,
   output logic [v_mem_axi_pkg::AXI_DATA_W-1:0] head_o,
   output logic                                empty_o,
   output logic                                full_o
);
   import v_mem_axi_pkg::*;
   import v_mem_xfer_pkg::*;

   logic [AXI_DATA_W-1:0]           mem [LANE_DEPTH];
   logic [$clog2(LANE_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(LANE_DEPTH)-1:0]   rd_ptr;
   logic [$clog2(LANE_DEPTH+1)-1:0] count;
   logic                            do_push;
   logic                            do_pop;

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   assign head_o  = mem[rd_ptr];
   assign empty_o = (count == '0);
   assign full_o  = (count == ($clog2(LANE_DEPTH+1))'(LANE_DEPTH));

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   // Pointers wrap at the lane depth, occupancy tracks push minus pop
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == ($clog2(LANE_DEPTH))'(LANE_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ($clog2(LANE_DEPTH))'(LANE_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- v_mem_xfer_pkg.sv
package v_mem_xfer_pkg;

   // Lane slicing of the element stream
   localparam int V_LANES    = 4;
   localparam int LANE_DEPTH = 4;
   localparam int LANE_IDX_W = $clog2(V_LANES);

   // Transfer length in 32-bit words
   localparam int XFER_SIZE_W = 16;

   // One copy command, both offsets are relative to the base address
   typedef struct packed {
      logic [v_mem_axi_pkg::AXI_ADDR_W-1:0] raddr_offset;
      logic [v_mem_axi_pkg::AXI_ADDR_W-1:0] waddr_offset;
      logic [XFER_SIZE_W-1:0]               xfer_size;
      logic                                 wstrb_msk_en;
      logic [v_mem_axi_pkg::AXI_STRB_W-1:0] wstrb_msk;
   } xfer_cmd_t;

endpackage

//--- v_mem_axi_pkg.sv
package v_mem_axi_pkg;

   // Bus geometry of the vector memory port
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int AXI_STRB_W = AXI_DATA_W / 8;

   // Longest INCR burst issued by either master
   localparam int MAX_BURST = 16;

   // Read address channel, len is beats minus one
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [7:0]            len;
   } ar_req_t;

   // Write address channel
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [7:0]            len;
   } aw_req_t;

   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic [AXI_STRB_W-1:0] strb;
      logic                  last;
   } w_beat_t;

   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic                  last;
   } r_beat_t;

endpackage
